/* logic/dhcp_pkg.sv */
package dhcp_pkg;

  // **************************************************************************
  // DHCP message type option values
  // **************************************************************************
  localparam logic [7:0] MSG_DISCOVER = 8'd1;
  localparam logic [7:0] MSG_OFFER    = 8'd2;
  localparam logic [7:0] MSG_REQUEST  = 8'd3;
  localparam logic [7:0] MSG_ACK      = 8'd5;
  localparam logic [7:0] MSG_NAK      = 8'd6;

  // BOOTP op field
  localparam logic [7:0] OP_REQUEST = 8'd1;
  localparam logic [7:0] OP_REPLY   = 8'd2;

  // Transaction id of this client
  localparam logic [31:0] DHCP_XID = 32'hdeadface;

  localparam logic [31:0] IP_BCAST = 32'hffffffff; // Limited broadcast

  // **************************************************************************
  // Timing
  // **************************************************************************
  localparam logic [15:0] ATTEMPT_CYCLES = 16'd64; // One wait for a reply
  localparam logic [3:0]  MAX_RETRIES    = 4'd3;   // Resends before giving up

  localparam logic [15:0] TICK_CYCLES = 16'd8; // Cycles per lease unit

  localparam int LEASE_W = 32;

endpackage

/* logic/dhcp_if.sv */
// One classified server reply
interface dhcp_rx_if;

  logic                        offer;
  logic                        ack;
  logic                        nak;
  logic [31:0]                 yiaddr;
  logic [31:0]                 server_id;
  logic [dhcp_pkg::LEASE_W-1:0] lease_time;

  modport filter (
    output offer, ack, nak, yiaddr, server_id, lease_time
  );

  modport core (
    input offer, ack, nak, yiaddr, server_id, lease_time
  );

endinterface

// Lease control and lease events
interface dhcp_lease_if;

  logic                        load;
  logic [dhcp_pkg::LEASE_W-1:0] lease_time;
  logic                        clear;
  logic                        renew;
  logic                        expire;

  modport core (
    output load, lease_time, clear,
    input  renew, expire
  );

  modport timer (
    input  load, lease_time, clear,
    output renew, expire
  );

endinterface

/* logic/dhcp_rx_filter.sv */
module dhcp_rx_filter #(
  parameter logic [47:0] MAC_ADDR = 48'h0
) (
  input  logic                         clk,
  input  logic                         fsm_rst,
  input  logic                         rx_val,
  input  logic [7:0]                   rx_op,
  input  logic [31:0]                  rx_xid,
  input  logic [47:0]                  rx_chaddr,
  input  logic [7:0]                   rx_msg_type,
  input  logic [31:0]                  rx_yiaddr,
  input  logic [31:0]                  rx_server_id,
  input  logic [dhcp_pkg::LEASE_W-1:0] rx_lease_time,
  dhcp_rx_if.filter                    rx
);

  logic for_us;

  // Reply to our own transaction and hardware address
  assign for_us = rx_val &&
                  (rx_op == dhcp_pkg::OP_REPLY) &&
                  (rx_xid == dhcp_pkg::DHCP_XID) &&
                  (rx_chaddr == MAC_ADDR);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rx.offer <= 1'b0;
      rx.ack   <= 1'b0;
      rx.nak   <= 1'b0;
    end else begin
      rx.offer <= for_us && (rx_msg_type == dhcp_pkg::MSG_OFFER);
      rx.ack   <= for_us && (rx_msg_type == dhcp_pkg::MSG_ACK);
      rx.nak   <= for_us && (rx_msg_type == dhcp_pkg::MSG_NAK);
    end
  end

  // Payload follows every strobe, no reset
  always_ff @(posedge clk) begin
    if (rx_val) begin
      rx.yiaddr     <= rx_yiaddr;
      rx.server_id  <= rx_server_id;
      rx.lease_time <= rx_lease_time;
    end
  end

  a_one_class : assert property (
    @(posedge clk) disable iff (fsm_rst)
    $onehot0({rx.offer, rx.ack, rx.nak})
  ) else $error("rx filter raised more than one class");

endmodule

/* logic/dhcp_retry_timer.sv */
module dhcp_retry_timer (
  input  logic clk,
  input  logic fsm_rst,
  input  logic start,
  input  logic stop,
  output logic resend,
  output logic give_up
);

  logic [15:0] cyc_cnt;
  logic [3:0]  retry_cnt;
  logic        armed;
  logic        expired;

  assign expired = armed && (cyc_cnt == dhcp_pkg::ATTEMPT_CYCLES - 16'd1);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      armed     <= 1'b0;
      cyc_cnt   <= '0;
      retry_cnt <= '0;
      resend    <= 1'b0;
      give_up   <= 1'b0;
    end else begin
      resend  <= 1'b0;
      give_up <= 1'b0;
      if (start) begin
        armed     <= 1'b1;
        cyc_cnt   <= '0;
        retry_cnt <= '0;
      end else if (stop) begin
        armed <= 1'b0;
      end else if (expired) begin
        cyc_cnt <= '0;
        if (retry_cnt == dhcp_pkg::MAX_RETRIES) begin
          give_up <= 1'b1; // Out of attempts
          armed   <= 1'b0;
        end else begin
          resend    <= 1'b1;
          retry_cnt <= retry_cnt + 4'd1;
        end
      end else if (armed) begin
        cyc_cnt <= cyc_cnt + 16'd1;
      end
    end
  end

  a_resend_xor_give_up : assert property (
    @(posedge clk) disable iff (fsm_rst)
    !(resend && give_up)
  ) else $error("resend and give_up together");

endmodule

/* logic/dhcp_lease_timer.sv */
module dhcp_lease_timer (
  input  logic         clk,
  input  logic         fsm_rst,
  dhcp_lease_if.timer  lease
);

  logic [15:0]                  pre_cnt;
  logic [dhcp_pkg::LEASE_W:0]   half_cnt;  // Elapsed half ticks
  logic [dhcp_pkg::LEASE_W:0]   half_next;
  logic [dhcp_pkg::LEASE_W-1:0] lease_q;
  logic                         running;
  logic                         half_tick;
  logic                         renewed;

  assign half_tick = running && (pre_cnt == (dhcp_pkg::TICK_CYCLES >> 1) - 16'd1);
  assign half_next = half_cnt + 1'b1;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      running      <= 1'b0;
      renewed      <= 1'b0;
      pre_cnt      <= '0;
      half_cnt     <= '0;
      lease.renew  <= 1'b0;
      lease.expire <= 1'b0;
    end else begin
      lease.renew  <= 1'b0;
      lease.expire <= 1'b0;
      if (lease.clear) begin
        running <= 1'b0;
      end else if (lease.load) begin
        running  <= 1'b1;
        renewed  <= 1'b0;
        pre_cnt  <= '0;
        half_cnt <= '0;
      end else if (half_tick) begin
        pre_cnt  <= '0;
        half_cnt <= half_next;
        if (half_next == {1'b0, lease_q}) begin
          lease.renew <= 1'b1; // Halfway through the lease
          renewed     <= 1'b1;
        end
        if (half_next == {lease_q, 1'b0}) begin
          lease.expire <= 1'b1;
          running      <= 1'b0;
        end
      end else if (running) begin
        pre_cnt <= pre_cnt + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lease.load) lease_q <= lease.lease_time;
  end

  a_renew_before_expire : assert property (
    @(posedge clk) disable iff (fsm_rst)
    lease.expire |-> renewed
  ) else $error("lease expired without renewal point");

endmodule

/* logic/dhcp_core.sv */
module dhcp_core (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        ipv4_req,
  input  logic [31:0] ipv4_addr,
  output logic [31:0] assigned_addr,
  output logic        ipv4_addr_val,
  output logic        ipv4_addr_timeout,
  output logic        ok,
  output logic        timeout,
  output logic        tx_val,
  output logic [7:0]  tx_msg_type,
  output logic [31:0] tx_xid,
  output logic [31:0] tx_ciaddr,
  output logic [31:0] tx_req_ip,
  output logic        tx_req_ip_pres,
  output logic [31:0] tx_server_id,
  output logic        tx_server_id_pres,
  output logic [31:0] tx_src_ip,
  output logic [31:0] tx_dst_ip,
  dhcp_rx_if.core     rx,
  dhcp_lease_if.core  lease,
  output logic        retry_start,
  output logic        retry_stop,
  input  logic        resend,
  input  logic        give_up
);

  enum logic [2:0] {
    idle_s, discover_s, selecting_s, request_s,
    requesting_s, bound_s, renew_s, renewing_s
  } fsm;

  logic [31:0] offered_ip;
  logic [31:0] server_ip;
  logic        resending; // Send caused by a timer resend

  // **************************************************************************
  // Control
  // **************************************************************************
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      fsm               <= idle_s;
      resending         <= 1'b0;
      tx_val            <= 1'b0;
      ok                <= 1'b0;
      timeout           <= 1'b0;
      ipv4_addr_val     <= 1'b0;
      ipv4_addr_timeout <= 1'b0;
      retry_start       <= 1'b0;
      retry_stop        <= 1'b0;
      lease.load        <= 1'b0;
      lease.clear       <= 1'b0;
    end else begin
      tx_val            <= 1'b0;
      ok                <= 1'b0;
      timeout           <= 1'b0;
      ipv4_addr_timeout <= 1'b0;
      retry_start       <= 1'b0;
      retry_stop        <= 1'b0;
      lease.load        <= 1'b0;
      lease.clear       <= 1'b0;
      if (lease.expire) begin // Wins over everything else
        fsm               <= idle_s;
        resending         <= 1'b0; // Next DISCOVER must rearm the timer
        ipv4_addr_val     <= 1'b0;
        ipv4_addr_timeout <= 1'b1;
        retry_stop        <= 1'b1;
        lease.clear       <= 1'b1;
      end else begin
        case (fsm)
          idle_s : if (ipv4_req) fsm <= discover_s;
          discover_s, request_s, renew_s : begin
            tx_val      <= 1'b1;
            retry_start <= !resending;
            resending   <= 1'b0;
            if (fsm == discover_s) fsm <= selecting_s;
            else if (fsm == request_s) fsm <= requesting_s;
            else fsm <= renewing_s;
          end
          selecting_s : begin
            if (rx.offer) begin
              retry_stop <= 1'b1;
              fsm        <= request_s;
            end else if (resend) begin
              resending <= 1'b1;
              fsm       <= discover_s;
            end else if (give_up) begin
              timeout     <= 1'b1;
              lease.clear <= 1'b1;
              fsm         <= idle_s;
            end
          end
          requesting_s : begin
            if (rx.ack) begin
              retry_stop    <= 1'b1;
              ipv4_addr_val <= 1'b1;
              ok            <= 1'b1;
              lease.load    <= 1'b1;
              fsm           <= bound_s;
            end else if (rx.nak) begin
              fsm <= discover_s; // Start over
            end else if (resend) begin
              resending <= 1'b1;
              fsm       <= request_s;
            end else if (give_up) begin
              timeout     <= 1'b1;
              lease.clear <= 1'b1;
              fsm         <= idle_s;
            end
          end
          bound_s : if (lease.renew) fsm <= renew_s;
          renewing_s : begin
            if (rx.ack) begin
              retry_stop <= 1'b1;
              ok         <= 1'b1;
              lease.load <= 1'b1;
              fsm        <= bound_s;
            end else if (resend) begin
              resending <= 1'b1;
              fsm       <= renew_s;
            end else if (give_up) begin
              fsm <= bound_s; // Address stays until expiry
            end
          end
          default : fsm <= idle_s;
        endcase
      end
    end
  end

  // **************************************************************************
  // Message fields and recorded server data
  // **************************************************************************
  always_ff @(posedge clk) begin
    if (fsm == selecting_s && rx.offer) begin
      offered_ip <= rx.yiaddr;
      server_ip  <= rx.server_id;
    end
    if ((fsm == requesting_s || fsm == renewing_s) && rx.ack && !lease.expire) begin
      assigned_addr    <= rx.yiaddr;
      lease.lease_time <= rx.lease_time;
    end
    tx_xid <= dhcp_pkg::DHCP_XID;
    case (fsm)
      discover_s : begin
        tx_msg_type       <= dhcp_pkg::MSG_DISCOVER;
        tx_ciaddr         <= '0;
        tx_req_ip         <= ipv4_addr;
        tx_req_ip_pres    <= (ipv4_addr != '0);
        tx_server_id      <= '0;
        tx_server_id_pres <= 1'b0;
        tx_src_ip         <= '0;
        tx_dst_ip         <= dhcp_pkg::IP_BCAST;
      end
      request_s : begin
        tx_msg_type       <= dhcp_pkg::MSG_REQUEST;
        tx_ciaddr         <= '0;
        tx_req_ip         <= offered_ip;
        tx_req_ip_pres    <= 1'b1;
        tx_server_id      <= server_ip;
        tx_server_id_pres <= 1'b1;
        tx_src_ip         <= '0;
        tx_dst_ip         <= dhcp_pkg::IP_BCAST;
      end
      renew_s : begin // Unicast to the leasing server
        tx_msg_type       <= dhcp_pkg::MSG_REQUEST;
        tx_ciaddr         <= assigned_addr;
        tx_req_ip         <= '0;
        tx_req_ip_pres    <= 1'b0;
        tx_server_id      <= '0;
        tx_server_id_pres <= 1'b0;
        tx_src_ip         <= assigned_addr;
        tx_dst_ip         <= server_ip;
      end
      default : ;
    endcase
  end

  a_tx_single_cycle : assert property (
    @(posedge clk) disable iff (fsm_rst)
    tx_val |=> !tx_val
  ) else $error("tx_val held for two cycles");

endmodule

/* logic/dhcp_client.sv */
module dhcp_client #(
  parameter logic [47:0] MAC_ADDR = 48'h02_00_00_00_00_01
) (
  input  logic                         clk,
  input  logic                         fsm_rst,
  input  logic                         ipv4_req,
  input  logic [31:0]                  ipv4_addr,
  output logic [31:0]                  assigned_addr,
  output logic                         ipv4_addr_val,
  output logic                         ipv4_addr_timeout,
  output logic                         ok,
  output logic                         timeout,
  input  logic                         rx_val,
  input  logic [7:0]                   rx_op,
  input  logic [31:0]                  rx_xid,
  input  logic [47:0]                  rx_chaddr,
  input  logic [7:0]                   rx_msg_type,
  input  logic [31:0]                  rx_yiaddr,
  input  logic [31:0]                  rx_server_id,
  input  logic [dhcp_pkg::LEASE_W-1:0] rx_lease_time,
  output logic                         tx_val,
  output logic [7:0]                   tx_msg_type,
  output logic [31:0]                  tx_xid,
  output logic [31:0]                  tx_ciaddr,
  output logic [31:0]                  tx_req_ip,
  output logic                         tx_req_ip_pres,
  output logic [31:0]                  tx_server_id,
  output logic                         tx_server_id_pres,
  output logic [31:0]                  tx_src_ip,
  output logic [31:0]                  tx_dst_ip
);

  logic retry_start;
  logic retry_stop;
  logic resend;
  logic give_up;

  dhcp_rx_if    rx_if ();
  dhcp_lease_if lease_if ();

  dhcp_rx_filter #(
    .MAC_ADDR (MAC_ADDR)
  ) dhcp_rx_filter_i (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .rx_val        (rx_val),
    .rx_op         (rx_op),
    .rx_xid        (rx_xid),
    .rx_chaddr     (rx_chaddr),
    .rx_msg_type   (rx_msg_type),
    .rx_yiaddr     (rx_yiaddr),
    .rx_server_id  (rx_server_id),
    .rx_lease_time (rx_lease_time),
    .rx            (rx_if.filter)
  );

  dhcp_retry_timer dhcp_retry_timer_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .start   (retry_start),
    .stop    (retry_stop),
    .resend  (resend),
    .give_up (give_up)
  );

  dhcp_lease_timer dhcp_lease_timer_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .lease   (lease_if.timer)
  );

  dhcp_core dhcp_core_i (
    .clk               (clk),
    .fsm_rst           (fsm_rst),
    .ipv4_req          (ipv4_req),
    .ipv4_addr         (ipv4_addr),
    .assigned_addr     (assigned_addr),
    .ipv4_addr_val     (ipv4_addr_val),
    .ipv4_addr_timeout (ipv4_addr_timeout),
    .ok                (ok),
    .timeout           (timeout),
    .tx_val            (tx_val),
    .tx_msg_type       (tx_msg_type),
    .tx_xid            (tx_xid),
    .tx_ciaddr         (tx_ciaddr),
    .tx_req_ip         (tx_req_ip),
    .tx_req_ip_pres    (tx_req_ip_pres),
    .tx_server_id      (tx_server_id),
    .tx_server_id_pres (tx_server_id_pres),
    .tx_src_ip         (tx_src_ip),
    .tx_dst_ip         (tx_dst_ip),
    .rx                (rx_if.core),
    .lease             (lease_if.core),
    .retry_start       (retry_start),
    .retry_stop        (retry_stop),
    .resend            (resend),
    .give_up           (give_up)
  );

endmodule

/* verification/dhcp_clk_gen.sv */
module dhcp_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic fsm_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    fsm_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0; // Released on a falling edge
  end

endmodule

/* verification/dhcp_client_tb.sv */
module dhcp_client_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD_NS = 40;
  localparam int ATTEMPT   = int'(dhcp_pkg::ATTEMPT_CYCLES);
  localparam int TICK      = int'(dhcp_pkg::TICK_CYCLES);
  localparam int RETRIES   = int'(dhcp_pkg::MAX_RETRIES);
  localparam int LEASE_MAX = 23;
  // Test lengths in cycles plus margin
  localparam int RUN_CYCLES = 12 * ATTEMPT + (RETRIES + 2) * ATTEMPT + 3 * LEASE_MAX * TICK + 400;
  localparam logic [47:0] MAC = 48'h02_12_34_56_78_9a;
  localparam logic [31:0] XID = dhcp_pkg::DHCP_XID;

  localparam int K_DISCOVER = 0;
  localparam int K_REQUEST  = 1;
  localparam int K_RENEW    = 2;
  localparam int EV_TX      = 0;
  localparam int EV_OK      = 1;
  localparam int EV_TIMEOUT = 2;
  localparam int EV_ADDR_TO = 3;

  typedef struct packed {
    logic [7:0]  msg_type;
    logic [31:0] ciaddr;
    logic [31:0] req_ip;
    logic        req_pres;
    logic [31:0] server_id;
    logic        sid_pres;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
  } tx_fields_t;

  logic clk, gen_rst, tb_rst, fsm_rst;
  logic ipv4_req, ipv4_addr_val, ipv4_addr_timeout, ok, timeout;
  logic [31:0] ipv4_addr, assigned_addr;
  logic rx_val;
  logic [7:0] rx_op, rx_msg_type;
  logic [31:0] rx_xid, rx_yiaddr, rx_server_id, rx_lease_time;
  logic [47:0] rx_chaddr;
  logic tx_val, tx_req_ip_pres, tx_server_id_pres;
  logic [7:0] tx_msg_type;
  logic [31:0] tx_xid, tx_ciaddr, tx_req_ip, tx_server_id, tx_src_ip, tx_dst_ip;

  logic [15:0] lfsr = 16'd36;
  int          err_cnt, check_cnt, tests_run, tests_failed, test_err0, test_idx;
  string       test_name;
  int          exp_kind;   // Updated with nonblocking writes only
  logic [31:0] exp_offer, exp_server, exp_bound;

  assign fsm_rst = gen_rst | tb_rst;

  dhcp_clk_gen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(2)) dhcp_clk_gen_i (
    .clk     (clk),
    .fsm_rst (gen_rst)
  );

  dhcp_client #(.MAC_ADDR(MAC)) dhcp_client_i (.*);

  // ***************************************************************************
  // Random numbers and expected values
  // ***************************************************************************
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] rnd_addr();
    return 32'h0a00_0000 | take_bits(24); // 10.x.x.x, never zero
  endfunction

  function automatic int snap_to_expected(input int want, input int seen, input int tol);
    if (seen >= want - tol && seen <= want + tol) return want;
    return seen;
  endfunction

  function automatic tx_fields_t ref_tx(input int kind, input logic [31:0] req_addr,
                                        input logic [31:0] offer, input logic [31:0] server,
                                        input logic [31:0] bound);
    tx_fields_t f;
    f = '0;
    f.msg_type = dhcp_pkg::MSG_REQUEST;
    f.dst_ip   = 32'hffff_ffff;
    case (kind)
      K_DISCOVER : begin
        f.msg_type = dhcp_pkg::MSG_DISCOVER;
        f.req_pres = (req_addr != 32'h0);
        f.req_ip   = f.req_pres ? req_addr : 32'h0;
      end
      K_REQUEST : begin
        f.req_ip    = offer;
        f.req_pres  = 1'b1;
        f.server_id = server;
        f.sid_pres  = 1'b1;
      end
      default : begin // Unicast renewal
        f.ciaddr = bound;
        f.src_ip = bound;
        f.dst_ip = server;
      end
    endcase
    return f;
  endfunction

  // ***************************************************************************
  // Checks and waits
  // ***************************************************************************
  task automatic check_val(input string name, input logic [31:0] want, input logic [31:0] seen);
    check_cnt++;
    if (seen !== want) begin
      err_cnt++;
      $display("ERROR %0t ns %s expected %h actual %h", $time, name, want, seen);
    end
  endtask

  always @(negedge clk) begin : compare_tx
    tx_fields_t want;
    if (tx_val === 1'b1) begin
      want = ref_tx(exp_kind, ipv4_addr, exp_offer, exp_server, exp_bound);
      check_val("tx_msg_type", want.msg_type, tx_msg_type);
      check_val("tx_xid", XID, tx_xid);
      check_val("tx_ciaddr", want.ciaddr, tx_ciaddr);
      check_val("tx_req_ip", want.req_ip, tx_req_ip);
      check_val("tx_req_ip_pres", want.req_pres, tx_req_ip_pres);
      check_val("tx_server_id", want.server_id, tx_server_id);
      check_val("tx_server_id_pres", want.sid_pres, tx_server_id_pres);
      check_val("tx_src_ip", want.src_ip, tx_src_ip);
      check_val("tx_dst_ip", want.dst_ip, tx_dst_ip);
    end
  end

  task automatic wait_event(input int ev, input int max_cycles, output bit got);
    int i;
    got = 1'b0;
    i = 0;
    while (!got && i < max_cycles) begin
      @(negedge clk);
      case (ev)
        EV_TX      : got = tx_val;
        EV_OK      : got = ok;
        EV_TIMEOUT : got = timeout;
        default    : got = ipv4_addr_timeout;
      endcase
      i++;
    end
  endtask

  task automatic expect_event(input int ev, input int max_cycles, input string what,
                              output bit got);
    wait_event(ev, max_cycles, got);
    if (!got) begin
      err_cnt++;
      $display("%0t ns: %s never came within %0d cycles", $time, what, max_cycles);
    end
  endtask

  // ***************************************************************************
  // Stimulus and server model
  // ***************************************************************************
  task automatic send_reply(input logic [7:0] op, input logic [31:0] xid,
                            input logic [47:0] chaddr, input logic [7:0] msg,
                            input logic [31:0] yiaddr, input logic [31:0] sid, input int lt);
    rx_op         = op;
    rx_xid        = xid;
    rx_chaddr     = chaddr;
    rx_msg_type   = msg;
    rx_yiaddr     = yiaddr;
    rx_server_id  = sid;
    rx_lease_time = lt;
    rx_val        = 1'b1;
    @(negedge clk);
    rx_val = 1'b0;
  endtask

  task automatic request_and_discover(input logic [31:0] addr);
    bit seen;
    exp_kind <= K_DISCOVER;
    ipv4_addr = addr;
    ipv4_req  = 1'b1;
    @(negedge clk);
    ipv4_req = 1'b0;
    expect_event(EV_TX, 8, "DISCOVER", seen);
  endtask

  task automatic offer_and_request(input logic [31:0] offer, input logic [31:0] server);
    bit seen;
    exp_kind   <= K_REQUEST;
    exp_offer  <= offer;
    exp_server <= server;
    send_reply(dhcp_pkg::OP_REPLY, XID, MAC, dhcp_pkg::MSG_OFFER, offer, server, 200);
    expect_event(EV_TX, 8, "REQUEST after offer", seen);
  endtask

  task automatic acquire_address(input logic [31:0] offer, input logic [31:0] server,
                                 input int lt, output time t_ack);
    bit seen;
    offer_and_request(offer, server);
    exp_kind  <= K_RENEW;
    exp_bound <= offer;
    t_ack = $time;
    send_reply(dhcp_pkg::OP_REPLY, XID, MAC, dhcp_pkg::MSG_ACK, offer, server, lt);
    expect_event(EV_OK, 8, "ok after ack", seen);
    check_val("ipv4_addr_val", 1, ipv4_addr_val);
    check_val("assigned_addr", offer, assigned_addr);
    @(negedge clk);
    check_val("ok", 0, ok); // Single cycle pulse
  endtask

  task automatic apply_reset();
    tb_rst = 1'b1;
    repeat (2) @(negedge clk);
    tb_rst = 1'b0;
    @(negedge clk);
  endtask

  task automatic start_test(input string name);
    test_idx++;
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt != test_err0) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", test_idx, test_name, err_cnt - test_err0);
    end else begin
      $display("test %0d %s: passed", test_idx, test_name);
    end
  endtask

  initial begin
    #(RUN_CYCLES * PERIOD_NS);
    $display("Watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : run_tests
    logic [31:0] offer, server;
    time         t_ack, t_last;
    int          lease;
    bit          got;
    tb_rst        = 1'b0;
    ipv4_req      = 1'b0;
    ipv4_addr     = '0;
    rx_val        = 1'b0;
    rx_op         = '0;
    rx_xid        = '0;
    rx_chaddr     = '0;
    rx_msg_type   = '0;
    rx_yiaddr     = '0;
    rx_server_id  = '0;
    rx_lease_time = '0;
    wait (gen_rst === 1'b1);
    wait (gen_rst === 1'b0);
    @(negedge clk);

    start_test("acquisition");
    request_and_discover(rnd_addr());
    acquire_address(rnd_addr(), rnd_addr(), 200, t_ack);
    end_test();
    apply_reset();

    start_test("filtering");
    request_and_discover(rnd_addr());
    offer  = rnd_addr();
    server = rnd_addr();
    for (int i = 0; i < 3; i++) begin // Foreign xid, foreign MAC, wrong op
      send_reply(i == 2 ? dhcp_pkg::OP_REQUEST : dhcp_pkg::OP_REPLY, i == 0 ? ~XID : XID,
                 i == 1 ? ~MAC : MAC, dhcp_pkg::MSG_OFFER, offer, server, 200);
      wait_event(EV_TX, 6, got);
      check_val("tx_val_after_bad_offer", 0, got);
    end
    offer_and_request(offer, server);
    end_test();
    apply_reset();

    start_test("retries");
    request_and_discover(32'h0);
    t_last = $time;
    for (int n = 0; n < RETRIES; n++) begin
      expect_event(EV_TX, ATTEMPT + 8, "resent DISCOVER", got);
      check_val("discover_gap", ATTEMPT,
                snap_to_expected(ATTEMPT, int'(($time - t_last) / PERIOD_NS), 4));
      t_last = $time;
    end
    expect_event(EV_TIMEOUT, ATTEMPT + 8, "timeout", got);
    wait_event(EV_TX, 20, got);
    check_val("tx_val_after_timeout", 0, got);
    wait_event(EV_TIMEOUT, 20, got);
    check_val("timeout_repeat", 0, got);
    check_val("ipv4_addr_val", 0, ipv4_addr_val);
    end_test();
    apply_reset();

    start_test("nak");
    request_and_discover(rnd_addr());
    server = rnd_addr();
    offer_and_request(rnd_addr(), server);
    exp_kind <= K_DISCOVER;
    send_reply(dhcp_pkg::OP_REPLY, XID, MAC, dhcp_pkg::MSG_NAK, 32'h0, server, 0);
    expect_event(EV_TX, 8, "DISCOVER after nak", got);
    check_val("ipv4_addr_val", 0, ipv4_addr_val);
    acquire_address(rnd_addr(), server, 200, t_ack);
    end_test();
    apply_reset();

    start_test("renewal and expiry");
    lease  = 8 + int'(take_bits(4));
    offer  = rnd_addr();
    server = rnd_addr();
    request_and_discover(rnd_addr());
    acquire_address(offer, server, lease, t_ack);
    expect_event(EV_TX, lease * TICK / 2 + 20, "renewal REQUEST", got);
    check_val("renew_delay", lease * TICK / 2,
              snap_to_expected(lease * TICK / 2, int'(($time - t_ack) / PERIOD_NS), 8));
    t_ack = $time;
    send_reply(dhcp_pkg::OP_REPLY, XID, MAC, dhcp_pkg::MSG_ACK, offer, server, lease);
    expect_event(EV_OK, 8, "ok after renewal ack", got);
    check_val("ipv4_addr_val", 1, ipv4_addr_val);
    check_val("assigned_addr", offer, assigned_addr);
    expect_event(EV_TX, lease * TICK / 2 + 20, "second renewal REQUEST", got);
    expect_event(EV_ADDR_TO, lease * TICK, "ipv4_addr_timeout", got); // Renewal left unanswered
    check_val("expire_delay", lease * TICK,
              snap_to_expected(lease * TICK, int'(($time - t_ack) / PERIOD_NS), 8));
    check_val("ipv4_addr_val", 0, ipv4_addr_val);
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
logic/dhcp_pkg.sv
logic/dhcp_if.sv
logic/dhcp_rx_filter.sv
logic/dhcp_retry_timer.sv
logic/dhcp_lease_timer.sv
logic/dhcp_core.sv
logic/dhcp_client.sv
verification/dhcp_clk_gen.sv
verification/dhcp_client_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dhcp_client_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timing -Wall --timescale $(TIMESCALE)
PASS_STR  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
